// ==== all.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/stepCounter.sv
hdl/divideUnit.sv
hdl/busDatapath.sv
hdl/controlSequencer.sv
hdl/divCore.sv
test/divCore_tb.sv

// ==== hdl/busDatapath.sv ====
`timescale 1ns/10ps

module busDatapath (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::ctrl_t ctrl,
    input  cpuPkg::word_t memData,
    input  cpuPkg::word_t regData,
    input  cpuPkg::word_t quotient,
    input  cpuPkg::word_t remainder,
    input  logic          divValid,
    output cpuPkg::word_t bus,
    output cpuPkg::word_t yOut,
    output cpuPkg::word_t outPort
);

    cpuPkg::word_t mdr;
    cpuPkg::word_t zReg;
    cpuPkg::word_t hiReg;
    cpuPkg::word_t loReg;
    cpuPkg::word_t aluResult;

    // One driver on the shared bus per cycle.
    always_comb begin
        case (ctrl.busSrc)
            cpuPkg::srcReg:  bus = regData;
            cpuPkg::srcMdr:  bus = mdr;
            cpuPkg::srcZLow: bus = zReg;
            cpuPkg::srcHi:   bus = hiReg;
            cpuPkg::srcLo:   bus = loReg;
            default:         bus = '0;  // Bus idle.
        endcase
    end

    always_comb begin
        unique case (ctrl.aluOp)
            cpuPkg::aluAdd: aluResult = yOut + bus;
            cpuPkg::aluSub: aluResult = yOut - bus;
            cpuPkg::aluAnd: aluResult = yOut & bus;
            cpuPkg::aluOr:  aluResult = yOut | bus;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.mdrIn) begin
            mdr <= ctrl.read ? memData : bus;  // Memory read or bus write.
        end
        if (ctrl.yIn) begin
            yOut <= bus;
        end
        if (ctrl.zIn) begin
            zReg <= aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hiReg   <= '0;
            loReg   <= '0;
            outPort <= '0;
        end else begin
            if (divValid) begin
                hiReg <= remainder;
                loReg <= quotient;
            end else begin
                if (ctrl.hiIn) begin
                    hiReg <= bus;
                end
                if (ctrl.loIn) begin
                    loReg <= bus;
                end
            end
            if (ctrl.outIn) begin
                outPort <= bus;
            end
        end
    end

endmodule

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  cpuPkg::instr_t instr,
    input  logic           divValid,
    output cpuPkg::ctrl_t  ctrl,
    output logic           busy,
    output logic           done
);

    cpuPkg::seqState_t state;
    cpuPkg::seqState_t stateNext;
    cpuPkg::instr_t    ir;
    cpuPkg::aluOp_t    aluSel;
    logic              isAlu;
    logic              isDiv;

    assign isAlu = ir.opcode inside {cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr};
    assign isDiv = (ir.opcode == cpuPkg::opDiv);

    always_comb begin
        case (ir.opcode)
            cpuPkg::opSub: aluSel = cpuPkg::aluSub;
            cpuPkg::opAnd: aluSel = cpuPkg::aluAnd;
            cpuPkg::opOr:  aluSel = cpuPkg::aluOr;
            default:       aluSel = cpuPkg::aluAdd;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuPkg::sIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpuPkg::sIdle && start) begin
            ir <= instr;                 // Start while busy is dropped.
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            cpuPkg::sIdle: if (start) stateNext = cpuPkg::sT0;
            cpuPkg::sT0:   stateNext = (ir.opcode == cpuPkg::opOut) ? cpuPkg::sDone : cpuPkg::sT1;
            cpuPkg::sT1:   stateNext = (isAlu || isDiv) ? cpuPkg::sT2 : cpuPkg::sDone;
            cpuPkg::sT2: begin
                if (!isDiv) begin
                    stateNext = cpuPkg::sDone;
                end else if (divValid) begin
                    stateNext = cpuPkg::sT3;  // HI and LO written this cycle.
                end
            end
            cpuPkg::sT3:   stateNext = cpuPkg::sDone;
            default:       stateNext = cpuPkg::sIdle;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            cpuPkg::sT0: begin
                ctrl.busSrc = cpuPkg::srcReg;
                case (ir.opcode)
                    cpuPkg::opLoad: begin
                        ctrl.busSrc = cpuPkg::srcNone;
                        ctrl.mdrIn  = 1'b1;
                        ctrl.read   = 1'b1;
                    end
                    cpuPkg::opMfhi: begin
                        ctrl.busSrc = cpuPkg::srcHi;
                        ctrl.mdrIn  = 1'b1;
                    end
                    cpuPkg::opMflo: begin
                        ctrl.busSrc = cpuPkg::srcLo;
                        ctrl.mdrIn  = 1'b1;
                    end
                    cpuPkg::opOut: begin
                        ctrl.regOutSel = ir.ra;
                        ctrl.outIn     = 1'b1;
                    end
                    default: begin       // ALU and divide take rb into Y.
                        ctrl.regOutSel = ir.rb;
                        ctrl.yIn       = 1'b1;
                    end
                endcase
            end
            cpuPkg::sT1: begin
                if (isAlu || isDiv) begin
                    ctrl.busSrc    = cpuPkg::srcReg;
                    ctrl.regOutSel = ir.rc;
                    ctrl.zIn       = isAlu;
                    ctrl.aluOp     = aluSel;
                    ctrl.divStart  = isDiv;
                end else begin
                    ctrl.busSrc       = cpuPkg::srcMdr;
                    ctrl.regIn[ir.ra] = 1'b1;
                end
            end
            cpuPkg::sT2: begin
                if (isAlu) begin
                    ctrl.busSrc       = cpuPkg::srcZLow;
                    ctrl.regIn[ir.ra] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign busy = (state != cpuPkg::sIdle);
    assign done = (state == cpuPkg::sDone);

endmodule

// ==== hdl/cpuDefs_defs.svh ====
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

// Datapath word width.
`define DATA_WIDTH 32

// General register file.
`define NUM_REGS      16
`define REG_IDX_WIDTH 4

`endif

// ==== hdl/cpuPkg.sv ====
`include "cpuDefs_defs.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0]    word_t;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdx_t;

    typedef enum logic [4:0] {
        opLoad,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opDiv,
        opMfhi,
        opMflo,
        opOut
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        regIdx_t ra;                      // Destination, or source for opOut.
        regIdx_t rb;                      // First operand.
        regIdx_t rc;                      // Second operand.
    } instr_t;

    typedef enum logic [2:0] {
        srcNone,
        srcReg,
        srcMdr,
        srcZLow,
        srcHi,
        srcLo
    } busSrc_t;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr
    } aluOp_t;

    typedef struct packed {
        logic [`NUM_REGS-1:0] regIn;      // One-hot register write.
        regIdx_t              regOutSel;
        busSrc_t              busSrc;
        logic                 mdrIn;
        logic                 read;
        logic                 yIn;
        logic                 zIn;
        logic                 hiIn;
        logic                 loIn;
        logic                 outIn;
        aluOp_t               aluOp;
        logic                 divStart;
    } ctrl_t;

    typedef enum logic [2:0] {
        sIdle,
        sT0,
        sT1,
        sT2,
        sT3,
        sDone
    } seqState_t;

endpackage

// ==== hdl/divCore.sv ====
`timescale 1ns/10ps

module divCore (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  cpuPkg::instr_t instr,
    input  cpuPkg::word_t  memData,
    output cpuPkg::word_t  outPort,
    output logic           busy,
    output logic           done
);

    cpuPkg::ctrl_t ctrl;
    cpuPkg::word_t bus;
    cpuPkg::word_t regData;
    cpuPkg::word_t yOut;
    cpuPkg::word_t quotient;
    cpuPkg::word_t remainder;
    logic          divValid;
    logic          lastStep;

    controlSequencer seq_i (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .instr    (instr),
        .divValid (divValid),
        .ctrl     (ctrl),
        .busy     (busy),
        .done     (done)
    );

    stepCounter counter_i (
        .clk      (clk),
        .reset    (reset),
        .load     (ctrl.divStart),
        .count    (),
        .lastStep (lastStep)
    );

    registerFile regs_i (
        .clk      (clk),
        .reset    (reset),
        .regIn    (ctrl.regIn),
        .bus      (bus),
        .readSel  (ctrl.regOutSel),
        .readData (regData)
    );

    busDatapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .memData   (memData),
        .regData   (regData),
        .quotient  (quotient),
        .remainder (remainder),
        .divValid  (divValid),
        .bus       (bus),
        .yOut      (yOut),
        .outPort   (outPort)
    );

    divideUnit divider_i (
        .clk       (clk),
        .reset     (reset),
        .divStart  (ctrl.divStart),
        .lastStep  (lastStep),
        .dividend  (yOut),                 // Y holds rb.
        .divisor   (bus),                  // rc is on the bus.
        .quotient  (quotient),
        .remainder (remainder),
        .divValid  (divValid)
    );

endmodule

// ==== hdl/divideUnit.sv ====
`timescale 1ns/10ps

module divideUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          divStart,
    input  logic          lastStep,
    input  cpuPkg::word_t dividend,
    input  cpuPkg::word_t divisor,
    output cpuPkg::word_t quotient,
    output cpuPkg::word_t remainder,
    output logic          divValid
);

    localparam int W = $bits(cpuPkg::word_t);

    cpuPkg::word_t accReg;               // Partial remainder.
    cpuPkg::word_t quoReg;               // Dividend bits out, quotient bits in.
    cpuPkg::word_t magDivisor;
    logic          quoNeg;
    logic          remNeg;
    logic          zeroDivisor;
    logic          running;
    logic [W:0]    shifted;
    logic [W:0]    trial;
    cpuPkg::word_t accNext;
    cpuPkg::word_t quoNext;

    // One restoring iteration.
    always_comb begin
        shifted = {accReg, quoReg[W-1]};
        trial   = shifted - {1'b0, magDivisor};
        if (trial[W]) begin              // Negative, restore.
            accNext = shifted[W-1:0];
            quoNext = {quoReg[W-2:0], 1'b0};
        end else begin
            accNext = trial[W-1:0];
            quoNext = {quoReg[W-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b0;
            divValid <= 1'b0;
        end else begin
            divValid <= running && lastStep;
            if (divStart) begin
                running <= 1'b1;
            end else if (lastStep) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            accReg      <= '0;
            quoReg      <= dividend[W-1] ? -dividend : dividend;
            magDivisor  <= divisor[W-1] ? -divisor : divisor;
            quoNeg      <= dividend[W-1] ^ divisor[W-1];
            remNeg      <= dividend[W-1];  // Remainder follows the dividend.
            zeroDivisor <= (divisor == '0);
        end else if (running) begin
            accReg <= accNext;
            quoReg <= quoNext;
        end
        if (running && lastStep) begin
            quotient  <= zeroDivisor ? '1 : (quoNeg ? -quoNext : quoNext);
            remainder <= remNeg ? -accNext : accNext;
        end
    end

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/10ps

`include "cpuDefs_defs.svh"

module registerFile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`NUM_REGS-1:0] regIn,
    input  cpuPkg::word_t        bus,
    input  cpuPkg::regIdx_t      readSel,
    output cpuPkg::word_t        readData
);

    cpuPkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    assign readData = regs[readSel];     // Asynchronous read onto the bus.

endmodule

// ==== hdl/stepCounter.sv ====
`timescale 1ns/10ps

module stepCounter (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    output logic [4:0] count,
    output logic       lastStep
);

    logic running;

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (load) begin
            count   <= 5'd31;            // 32 divider iterations.
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 5'd1;
            end
        end
    end

    assign lastStep = running && (count == '0);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module divCore_tb -o simv \
    && ./obj_dir/simv | tee sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed." || { echo "Simulation failed."; exit 1; }

// ==== test/divCore_tb.sv ====
`timescale 1ns/10ps

module divCore_tb;

    localparam int NUM_OPS = 240;                      // Operations over all six tests.
    localparam int OP_LIMIT = 48;                      // Longest divide plus handshake.
    localparam int TIMEOUT_CYCLES = NUM_OPS * OP_LIMIT + 8 + 200;
    localparam cpuPkg::word_t MIN_WORD = 32'h8000_0000;

    logic           clk;
    logic           reset;
    logic           start;
    cpuPkg::instr_t instr;
    cpuPkg::word_t  memData;
    cpuPkg::word_t  outPort;
    logic           busy;
    logic           done;

    cpuPkg::word_t  modelRegs [16];
    cpuPkg::word_t  modelHi;
    cpuPkg::word_t  modelLo;
    int             errors;
    int             checks;
    int             cycleCount;

    divCore dut_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .instr   (instr),
        .memData (memData),
        .outPort (outPort),
        .busy    (busy),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, an operation never finished.", cycleCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic compareWord(string name, cpuPkg::word_t actual, cpuPkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic compareFlag(string name, logic actual, logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic int expectedLatency(cpuPkg::opcode_t opc);
        case (opc)
            cpuPkg::opOut:                                  return 2;
            cpuPkg::opLoad, cpuPkg::opMfhi, cpuPkg::opMflo: return 3;
            default:                                        return 4;
        endcase
    endfunction

    task automatic modelApply(cpuPkg::instr_t op, cpuPkg::word_t data);
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        a = modelRegs[op.rb];
        b = modelRegs[op.rc];
        case (op.opcode)
            cpuPkg::opLoad: modelRegs[op.ra] = data;
            cpuPkg::opAdd:  modelRegs[op.ra] = a + b;
            cpuPkg::opSub:  modelRegs[op.ra] = a - b;
            cpuPkg::opAnd:  modelRegs[op.ra] = a & b;
            cpuPkg::opOr:   modelRegs[op.ra] = a | b;
            cpuPkg::opMfhi: modelRegs[op.ra] = modelHi;
            cpuPkg::opMflo: modelRegs[op.ra] = modelLo;
            cpuPkg::opDiv: begin
                if (b == '0) begin
                    modelLo = '1;
                    modelHi = a;
                end else if (a == MIN_WORD && b == '1) begin
                    modelLo = a;                       // Overflow keeps the dividend.
                    modelHi = '0;
                end else begin
                    modelLo = $signed(a) / $signed(b);  // Truncates toward zero.
                    modelHi = $signed(a) % $signed(b);
                end
            end
            default: ;
        endcase
    endtask

    task automatic issue(cpuPkg::opcode_t opc, cpuPkg::regIdx_t dst,
                         cpuPkg::word_t data = '0, cpuPkg::regIdx_t srcA = '0,
                         cpuPkg::regIdx_t srcB = '0, logic intrude = 1'b0);
        cpuPkg::instr_t op;
        int             cycles;
        op = '{opc, dst, srcA, srcB};
        cycles = 0;
        @(posedge clk);
        start   <= 1'b1;
        instr   <= op;
        memData <= data;
        do begin
            @(posedge clk);
            start <= intrude && cycles == 1;           // Lands while busy.
            if (intrude && cycles == 1) begin
                instr   <= '{cpuPkg::opLoad, dst, srcA, srcB};
                memData <= ~data;
            end
            @(negedge clk);
            cycles++;
            compareFlag("busy", busy, 1'b1);
        end while (!done && cycles < OP_LIMIT);
        if (!done) begin
            errors++;
            $display("Operation %s gave no done within %0d cycles.", opc.name(), OP_LIMIT);
        end else if (opc == cpuPkg::opDiv) begin
            compareFlag("divLatencyInWindow", cycles >= 34 && cycles <= 40, 1'b1);
        end else begin
            compareWord("doneLatency", cpuPkg::word_t'(cycles),
                        cpuPkg::word_t'(expectedLatency(opc)));
        end
        @(negedge clk);
        compareFlag("done", done, 1'b0);
        compareFlag("busy", busy, 1'b0);
        modelApply(op, data);
        if (opc == cpuPkg::opOut) begin
            compareWord("outPort", outPort, modelRegs[dst]);
        end
    endtask

    task automatic checkResetState();
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        compareFlag("busy", busy, 1'b0);
        compareFlag("done", done, 1'b0);
        compareWord("outPort", outPort, '0);
        for (int i = 0; i < 16; i += 5) begin
            issue(cpuPkg::opOut, cpuPkg::regIdx_t'(i));
        end
    endtask

    task automatic loadAndOutput();
        issue(cpuPkg::opLoad, 4'd1, 32'd0);
        issue(cpuPkg::opLoad, 4'd2, 32'd16);
        issue(cpuPkg::opLoad, 4'd3, 32'hFFFF_FFFE);
        for (int i = 1; i <= 3; i++) begin
            issue(cpuPkg::opOut, cpuPkg::regIdx_t'(i));
        end
    endtask

    task automatic divideBasic();
        issue(cpuPkg::opDiv, 4'd0, '0, 4'd2, 4'd3);
        issue(cpuPkg::opMflo, 4'd4);
        issue(cpuPkg::opMfhi, 4'd5);
        issue(cpuPkg::opOut, 4'd4);
        compareWord("outPort", outPort, 32'hFFFF_FFF8);  // 16 / -2
        issue(cpuPkg::opOut, 4'd5);
        compareWord("outPort", outPort, 32'h0000_0000);
    endtask

    task automatic divideAndCheck(cpuPkg::word_t a, cpuPkg::word_t b);
        issue(cpuPkg::opLoad, 4'd6, a);
        issue(cpuPkg::opLoad, 4'd7, b);
        issue(cpuPkg::opDiv, 4'd0, '0, 4'd6, 4'd7);
        issue(cpuPkg::opMflo, 4'd8);
        issue(cpuPkg::opOut, 4'd8);
        issue(cpuPkg::opMfhi, 4'd9);
        issue(cpuPkg::opOut, 4'd9);
    endtask

    task automatic divideRandom();
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        for (int i = 0; i < 20; i++) begin
            a = $urandom();
            if (i % 2 == 1) begin
                a[31] = 1'b1;                          // Negative dividend.
            end
            b = $urandom() >> $urandom_range(31, 4);
            if ($urandom_range(1, 0) == 1) begin
                b = -b;
            end
            divideAndCheck(a, b);
        end
    endtask

    task automatic divideCorners();
        divideAndCheck(32'h0000_1234, '0);
        divideAndCheck(32'hFFFF_FF00, '0);
        divideAndCheck(MIN_WORD, '1);
    endtask

    task automatic aluRandom();
        cpuPkg::opcode_t aluOps [4];
        aluOps = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr};
        for (int i = 0; i < 16; i++) begin
            issue(cpuPkg::opLoad, 4'd10, $urandom());
            issue(cpuPkg::opLoad, 4'd11, $urandom());
            issue(aluOps[i % 4], 4'd12, $urandom(), 4'd10, 4'd11, i % 3 == 0);
            issue(cpuPkg::opOut, 4'd12);
        end
    endtask

    initial begin
        void'($urandom(78));
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        reset      = 1'b1;
        start      = 1'b0;
        instr      = '0;
        memData    = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkResetState();
        loadAndOutput();
        divideBasic();
        divideRandom();
        divideCorners();
        aluRandom();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
